// File: include/pwo_macros.svh
// Pointwise unit constants
`ifndef PWO_MACROS_SVH
`define PWO_MACROS_SVH

// ========================================
// Coefficient arithmetic
// ========================================

// ML-DSA modulus, 2^23 - 2^13 + 1
`define PWO_Q           23'd8380417
`define PWO_COEFF_W     23
// Slot width in a memory word, one pad bit on top
`define PWO_REG_W       24

// Barrett reduction of a 46-bit product
// floor(2^46 / q), leaves the remainder below 2q
`define PWO_BARRETT_MU  24'd8396807
`define PWO_BARRETT_K   46

// ========================================
// Memory organisation
// ========================================

`define PWO_LANES       4
`define PWO_WORD_W      96
`define PWO_ADDR_W      15
// 256 coefficients at four per word
`define PWO_WORDS       64

`endif

// File: verilog/pwo_pkg.sv
// Pointwise unit types
`include "pwo_macros.svh"

package pwo_pkg;

    // ========================================
    // Data and address types
    // ========================================

    // One coefficient, always reduced below q
    typedef logic [`PWO_COEFF_W-1:0] coeff_t;

    // Four padded coefficients, lane 0 in the low slot
    typedef logic [`PWO_WORD_W-1:0] mem_word_t;

    typedef logic [`PWO_ADDR_W-1:0] mem_addr_t;

    // Word position inside one polynomial
    typedef logic [$clog2(`PWO_WORDS)-1:0] word_idx_t;

    // ========================================
    // Enums
    // ========================================

    typedef enum logic [1:0] {
        PWO_MUL = 2'd0,
        PWO_ADD = 2'd1,
        PWO_SUB = 2'd2
    } pwo_mode_e;

    // Sweep controller states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_DRAIN = 2'd2,
        ST_DONE  = 2'd3
    } ctrl_state_e;

endpackage

// File: verilog/pwo_issue_if.sv
// Issue channel, controller to datapath
`timescale 1ns/1ns

interface pwo_issue_if;

    // Read of one word issued this cycle
    logic                issue_valid;
    pwo_pkg::word_idx_t  issue_idx;
    // Word 63 of the sweep
    logic                issue_last;
    // Write of the last word goes out this cycle
    logic                last_written;

    modport ctrl (
        output issue_valid,
        output issue_idx,
        output issue_last,
        input  last_written
    );

    modport dp (
        input  issue_valid,
        input  issue_idx,
        input  issue_last,
        output last_written
    );

endinterface

// File: verilog/pwo_lane.sv
// Modular arithmetic lane, three stages
`timescale 1ns/1ns
`include "pwo_macros.svh"

module pwo_lane (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  pwo_pkg::pwo_mode_e  mode_i,
    input  logic                accumulate_i,
    input  pwo_pkg::coeff_t     a_i,
    input  pwo_pkg::coeff_t     b_i,
    input  pwo_pkg::coeff_t     c_i,
    output pwo_pkg::coeff_t     r_o
);
    import pwo_pkg::*;

    localparam int PROD_W = 2 * `PWO_COEFF_W;
    localparam int EST_W  = `PWO_BARRETT_K + `PWO_COEFF_W;

    // Folds a value below 2q into the range [0, q)
    function automatic coeff_t cond_sub_q(input logic [`PWO_REG_W-1:0] x);
        logic [`PWO_REG_W-1:0] y;
        y = (x >= `PWO_Q) ? x - `PWO_Q : x;
        return y[`PWO_COEFF_W-1:0];
    endfunction

    // Stage 1 registers
    logic [PROD_W-1:0]     prod_q;
    logic [`PWO_REG_W-1:0] sum_q;
    logic [`PWO_REG_W-1:0] diff_q;
    coeff_t                c_s1_q;

    // Stage 2 registers
    coeff_t                red_q;
    logic [`PWO_REG_W-1:0] sum_s2_q;
    logic [`PWO_REG_W-1:0] diff_s2_q;
    coeff_t                c_s2_q;

    // Barrett terms
    logic [EST_W-1:0]      est;
    coeff_t                qhat;
    logic [`PWO_REG_W-1:0] rem;

    // Stage 3 terms
    logic [`PWO_REG_W-1:0] acc_sum;
    logic [`PWO_REG_W-1:0] diff_fix;
    coeff_t                r_d;

    // ========================================
    // Barrett reduction
    // ========================================

    // Quotient estimate is low by at most one
    assign est  = prod_q * `PWO_BARRETT_MU;
    assign qhat = est[`PWO_BARRETT_K +: `PWO_COEFF_W];
    // True remainder is below 2q so 24 bits are enough
    assign rem  = prod_q[`PWO_REG_W-1:0] - qhat * `PWO_Q;

    // ========================================
    // Result select
    // ========================================

    assign acc_sum  = red_q + c_s2_q;
    // Negative difference wraps, adding q brings it back in range
    assign diff_fix = diff_s2_q + `PWO_Q;

    always_comb begin
        unique case (mode_i)
            PWO_MUL: r_d = accumulate_i ? cond_sub_q(acc_sum) : red_q;
            PWO_ADD: r_d = cond_sub_q(sum_s2_q);
            PWO_SUB: r_d = diff_s2_q[`PWO_REG_W-1] ? diff_fix[`PWO_COEFF_W-1:0]
                                                   : diff_s2_q[`PWO_COEFF_W-1:0];
            default: r_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            {prod_q, sum_q, diff_q, c_s1_q}         <= '0;
            {red_q, sum_s2_q, diff_s2_q, c_s2_q}    <= '0;
            r_o                                     <= '0;
        end else if (zeroize_i) begin
            {prod_q, sum_q, diff_q, c_s1_q}         <= '0;
            {red_q, sum_s2_q, diff_s2_q, c_s2_q}    <= '0;
            r_o                                     <= '0;
        end else begin
            prod_q    <= a_i * b_i;
            sum_q     <= a_i + b_i;
            diff_q    <= a_i - b_i;
            c_s1_q    <= c_i;
            red_q     <= cond_sub_q(rem);
            sum_s2_q  <= sum_q;
            diff_s2_q <= diff_q;
            c_s2_q    <= c_s1_q;
            r_o       <= r_d;
        end
    end

endmodule

// File: verilog/pwo_ctrl.sv
// Pointwise sweep controller
`timescale 1ns/1ns
`include "pwo_macros.svh"

module pwo_ctrl (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  logic                 enable_i,
    input  logic                 sampler_valid_i,
    input  logic                 accumulate_i,
    input  pwo_pkg::pwo_mode_e   mode_i,
    input  pwo_pkg::mem_addr_t   base_a_i,
    input  pwo_pkg::mem_addr_t   base_b_i,
    input  pwo_pkg::mem_addr_t   base_c_i,
    output logic                 a_rd_en_o,
    output logic                 b_rd_en_o,
    output logic                 c_rd_en_o,
    output pwo_pkg::mem_addr_t   a_rd_addr_o,
    output pwo_pkg::mem_addr_t   b_rd_addr_o,
    output pwo_pkg::mem_addr_t   c_rd_addr_o,
    output logic                 busy_o,
    output logic                 done_o,
    pwo_issue_if.ctrl            issue
);
    import pwo_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    word_idx_t   idx_q;
    pwo_mode_e   mode_q;
    logic        acc_q;
    logic        issue_fire;
    logic        idx_last;

    // One word per cycle while the sampler gate is open
    assign issue_fire = (state_q == ST_RUN) && sampler_valid_i;
    assign idx_last   = (idx_q == word_idx_t'(`PWO_WORDS - 1));

    // ========================================
    // State machine
    // ========================================

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE:  if (enable_i) state_d = ST_RUN;
            ST_RUN:   if (issue_fire && idx_last) state_d = ST_DRAIN;
            // Wait for the pipeline to flush the last word
            ST_DRAIN: if (issue.last_written) state_d = ST_DONE;
            ST_DONE:  state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= ST_IDLE;
            idx_q   <= '0;
            mode_q  <= PWO_MUL;
            acc_q   <= 1'b0;
        end else if (zeroize_i) begin
            state_q <= ST_IDLE;
            idx_q   <= '0;
            mode_q  <= PWO_MUL;
            acc_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE && enable_i) begin
                // Mode and accumulate fixed for the whole run
                idx_q  <= '0;
                mode_q <= mode_i;
                acc_q  <= accumulate_i;
            end else if (issue_fire) begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // ========================================
    // Memory reads and issue channel
    // ========================================

    assign a_rd_en_o = issue_fire;
    assign b_rd_en_o = issue_fire;
    // Old c only needed for multiply-accumulate
    assign c_rd_en_o = issue_fire && (mode_q == PWO_MUL) && acc_q;

    assign a_rd_addr_o = base_a_i + mem_addr_t'(idx_q);
    assign b_rd_addr_o = base_b_i + mem_addr_t'(idx_q);
    assign c_rd_addr_o = base_c_i + mem_addr_t'(idx_q);

    assign issue.issue_valid = issue_fire;
    assign issue.issue_idx   = idx_q;
    assign issue.issue_last  = idx_last;

    assign busy_o = (state_q == ST_RUN) || (state_q == ST_DRAIN);
    assign done_o = (state_q == ST_DONE);

endmodule

// File: verilog/pwo_datapath.sv
// Pointwise datapath, four lanes
`timescale 1ns/1ns
`include "pwo_macros.svh"

module pwo_datapath (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  pwo_pkg::pwo_mode_e  mode_i,
    input  logic                accumulate_i,
    input  pwo_pkg::mem_addr_t  base_c_i,
    input  pwo_pkg::mem_word_t  a_rd_data_i,
    input  pwo_pkg::mem_word_t  b_rd_data_i,
    input  pwo_pkg::mem_word_t  c_rd_data_i,
    output logic                c_wr_en_o,
    output pwo_pkg::mem_addr_t  c_wr_addr_o,
    output pwo_pkg::mem_word_t  c_wr_data_o,
    pwo_issue_if.dp             issue
);
    import pwo_pkg::*;

    // Read data, operand register, three lane stages
    localparam int PIPE_DEPTH = 5;

    mem_word_t             a_q;
    mem_word_t             b_q;
    mem_word_t             c_q;
    logic [PIPE_DEPTH-1:0] valid_sr;
    logic [PIPE_DEPTH-1:0] last_sr;
    word_idx_t             idx_sr [PIPE_DEPTH];
    coeff_t                lane_r [`PWO_LANES];

    // ========================================
    // Operand and control pipeline
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_sr <= '0;
            last_sr  <= '0;
            for (int i = 0; i < PIPE_DEPTH; i++) idx_sr[i] <= '0;
            {a_q, b_q, c_q} <= '0;
        end else if (zeroize_i) begin
            valid_sr <= '0;
            last_sr  <= '0;
            for (int i = 0; i < PIPE_DEPTH; i++) idx_sr[i] <= '0;
            {a_q, b_q, c_q} <= '0;
        end else begin
            valid_sr  <= {valid_sr[PIPE_DEPTH-2:0], issue.issue_valid};
            last_sr   <= {last_sr[PIPE_DEPTH-2:0], issue.issue_last};
            idx_sr[0] <= issue.issue_idx;
            for (int i = 1; i < PIPE_DEPTH; i++) idx_sr[i] <= idx_sr[i-1];
            // Memory data is valid one cycle after the read
            if (valid_sr[0]) begin
                a_q <= a_rd_data_i;
                b_q <= b_rd_data_i;
                c_q <= c_rd_data_i;
            end
        end
    end

    // ========================================
    // Lanes
    // ========================================

    for (genvar g = 0; g < `PWO_LANES; g++) begin : g_lane
        pwo_lane lane_i (
            .clk          (clk),
            .reset_n      (reset_n),
            .zeroize_i    (zeroize_i),
            .mode_i       (mode_i),
            .accumulate_i (accumulate_i),
            .a_i          (a_q[g*`PWO_REG_W +: `PWO_COEFF_W]),
            .b_i          (b_q[g*`PWO_REG_W +: `PWO_COEFF_W]),
            .c_i          (c_q[g*`PWO_REG_W +: `PWO_COEFF_W]),
            .r_o          (lane_r[g])
        );
    end

    // Pad bits always written as zero
    always_comb begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            c_wr_data_o[i*`PWO_REG_W +: `PWO_REG_W] =
                {{(`PWO_REG_W-`PWO_COEFF_W){1'b0}}, lane_r[i]};
        end
    end

    assign c_wr_en_o          = valid_sr[PIPE_DEPTH-1];
    assign c_wr_addr_o        = base_c_i + mem_addr_t'(idx_sr[PIPE_DEPTH-1]);
    assign issue.last_written = valid_sr[PIPE_DEPTH-1] && last_sr[PIPE_DEPTH-1];

endmodule

// File: verilog/pwo_top.sv
// ML-DSA pointwise operation unit
`timescale 1ns/1ns

module pwo_top (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                enable_i,
    input  pwo_pkg::pwo_mode_e  mode_i,
    input  logic                accumulate_i,
    input  logic                sampler_valid_i,
    input  pwo_pkg::mem_addr_t  base_a_i,
    input  pwo_pkg::mem_addr_t  base_b_i,
    input  pwo_pkg::mem_addr_t  base_c_i,
    input  pwo_pkg::mem_word_t  a_rd_data_i,
    input  pwo_pkg::mem_word_t  b_rd_data_i,
    input  pwo_pkg::mem_word_t  c_rd_data_i,
    output logic                a_rd_en_o,
    output logic                b_rd_en_o,
    output logic                c_rd_en_o,
    output pwo_pkg::mem_addr_t  a_rd_addr_o,
    output pwo_pkg::mem_addr_t  b_rd_addr_o,
    output pwo_pkg::mem_addr_t  c_rd_addr_o,
    output logic                c_wr_en_o,
    output pwo_pkg::mem_addr_t  c_wr_addr_o,
    output pwo_pkg::mem_word_t  c_wr_data_o,
    output logic                busy_o,
    output logic                done_o
);
    import pwo_pkg::*;

    pwo_issue_if issue_if0 ();

    // Sweep control and read addressing
    pwo_ctrl ctrl0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .enable_i        (enable_i),
        .sampler_valid_i (sampler_valid_i),
        .accumulate_i    (accumulate_i),
        .mode_i          (mode_i),
        .base_a_i        (base_a_i),
        .base_b_i        (base_b_i),
        .base_c_i        (base_c_i),
        .a_rd_en_o       (a_rd_en_o),
        .b_rd_en_o       (b_rd_en_o),
        .c_rd_en_o       (c_rd_en_o),
        .a_rd_addr_o     (a_rd_addr_o),
        .b_rd_addr_o     (b_rd_addr_o),
        .c_rd_addr_o     (c_rd_addr_o),
        .busy_o          (busy_o),
        .done_o          (done_o),
        .issue           (issue_if0.ctrl)
    );

    // Arithmetic and result write, mode held stable by the host
    pwo_datapath dp0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .base_c_i     (base_c_i),
        .a_rd_data_i  (a_rd_data_i),
        .b_rd_data_i  (b_rd_data_i),
        .c_rd_data_i  (c_rd_data_i),
        .c_wr_en_o    (c_wr_en_o),
        .c_wr_addr_o  (c_wr_addr_o),
        .c_wr_data_o  (c_wr_data_o),
        .issue        (issue_if0.dp)
    );

endmodule

// File: tb/pwo_tb.sv
// Pointwise unit testbench
`timescale 1ns/1ns
`include "pwo_macros.svh"

module pwo_tb;
    import pwo_pkg::*;

    localparam int     NUM_TESTS   = 7;
    localparam int     CYCLE_LIMIT = 4 * 100 * NUM_TESTS;
    localparam int     MEM_DEPTH   = 1 << `PWO_ADDR_W;
    localparam longint Q           = `PWO_Q;

    typedef struct {
        string     name;
        pwo_mode_e mode;
        logic      acc;
        logic      stall;
        logic      zero;
        mem_addr_t base_a;
        mem_addr_t base_b;
        mem_addr_t base_c;
    } test_t;

    logic      clk;
    logic      reset_n;
    logic      zeroize_i;
    logic      enable_i;
    logic      accumulate_i;
    logic      sampler_valid_i;
    pwo_mode_e mode_i;
    mem_addr_t base_a_i;
    mem_addr_t base_b_i;
    mem_addr_t base_c_i;
    logic      a_rd_en_o;
    logic      b_rd_en_o;
    logic      c_rd_en_o;
    mem_addr_t a_rd_addr_o;
    mem_addr_t b_rd_addr_o;
    mem_addr_t c_rd_addr_o;
    logic      c_wr_en_o;
    mem_addr_t c_wr_addr_o;
    mem_word_t c_wr_data_o;
    logic      busy_o;
    logic      done_o;
    mem_word_t a_rd_data = '0;
    mem_word_t b_rd_data = '0;
    mem_word_t c_rd_data = '0;

    mem_word_t   mem_a [MEM_DEPTH];
    mem_word_t   mem_b [MEM_DEPTH];
    mem_word_t   mem_c [MEM_DEPTH];
    coeff_t      exp_lane [`PWO_WORDS][`PWO_LANES];
    logic        c_read [`PWO_WORDS];
    test_t       tests [NUM_TESTS];
    test_t       cur;
    logic [31:0] lfsr;
    int          rd_count;
    int          wr_count;
    int          done_cnt;
    int          cycle_cnt = 0;
    logic        issuing = 1'b0;
    logic        exp_rd;

    pwo_top dut0 (
        .clk (clk), .reset_n (reset_n), .zeroize_i (zeroize_i), .enable_i (enable_i),
        .mode_i (mode_i), .accumulate_i (accumulate_i), .sampler_valid_i (sampler_valid_i),
        .base_a_i (base_a_i), .base_b_i (base_b_i), .base_c_i (base_c_i),
        .a_rd_data_i (a_rd_data), .b_rd_data_i (b_rd_data), .c_rd_data_i (c_rd_data),
        .a_rd_en_o (a_rd_en_o), .b_rd_en_o (b_rd_en_o), .c_rd_en_o (c_rd_en_o),
        .a_rd_addr_o (a_rd_addr_o), .b_rd_addr_o (b_rd_addr_o), .c_rd_addr_o (c_rd_addr_o),
        .c_wr_en_o (c_wr_en_o), .c_wr_addr_o (c_wr_addr_o), .c_wr_data_o (c_wr_data_o),
        .busy_o (busy_o), .done_o (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // Compare tasks and reference model
    // ========================================

    task automatic check_coeff(input string what, input coeff_t exp, input coeff_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %0d actual %0d", cur.name, what, exp, act);
            $display("** FAIL **");
            $fatal(1, "coefficient mismatch");
        end
    endtask

    task automatic check_addr(input string what, input mem_addr_t exp, input mem_addr_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected 'h%0h actual 'h%0h", cur.name, what, exp, act);
            $display("** FAIL **");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s %s expected %0b actual %0b", cur.name, what, exp, act);
            $display("** FAIL **");
            $fatal(1, "flag mismatch");
        end
    endtask

    function automatic coeff_t model_coeff(input pwo_mode_e mode, input logic acc,
                                           input coeff_t a, input coeff_t b, input coeff_t c);
        longint r;
        case (mode)
            PWO_MUL: r = acc ? ((longint'(a) * longint'(b)) % Q + longint'(c)) % Q
                             : (longint'(a) * longint'(b)) % Q;
            PWO_ADD: r = (longint'(a) + longint'(b)) % Q;
            PWO_SUB: r = (longint'(a) - longint'(b) < 0) ? longint'(a) - longint'(b) + Q
                                                       : longint'(a) - longint'(b);
            default: r = 0;
        endcase
        return coeff_t'(r);
    endfunction

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic next_coeff(output coeff_t v);
        logic [31:0] r;
        rand_bits(`PWO_COEFF_W, r);
        v = (r[22:0] >= `PWO_Q) ? r[22:0] - `PWO_Q : r[22:0];
    endtask

    // ========================================
    // Memory models and bus monitor
    // ========================================

    always @(posedge clk) begin
        if (a_rd_en_o) a_rd_data <= mem_a[a_rd_addr_o];
        if (b_rd_en_o) b_rd_data <= mem_b[b_rd_addr_o];
        if (c_rd_en_o) c_rd_data <= mem_c[c_rd_addr_o];
        if (c_wr_en_o) mem_c[c_wr_addr_o] = c_wr_data_o;
    end

    always @(posedge clk) begin
        if (reset_n) begin
            // One read per open sampler cycle until the sweep is issued
            exp_rd = issuing && sampler_valid_i;
            check_flag("a_rd_en", exp_rd, a_rd_en_o);
            check_flag("b_rd_en", exp_rd, b_rd_en_o);
            check_flag("c_rd_en", exp_rd && cur.mode == PWO_MUL && cur.acc, c_rd_en_o);
            if (exp_rd) begin
                check_addr("a_rd_addr", cur.base_a + mem_addr_t'(rd_count), a_rd_addr_o);
                check_addr("b_rd_addr", cur.base_b + mem_addr_t'(rd_count), b_rd_addr_o);
                if (c_rd_en_o) begin
                    check_addr("c_rd_addr", cur.base_c + mem_addr_t'(rd_count), c_rd_addr_o);
                    c_read[rd_count] = 1'b1;
                end
                rd_count++;
            end
            if (c_wr_en_o) begin
                check_flag("write count in range", 1'b1, wr_count < `PWO_WORDS);
                check_addr("c_wr_addr", cur.base_c + mem_addr_t'(wr_count), c_wr_addr_o);
                if (cur.acc && cur.mode == PWO_MUL) begin
                    check_flag("old c read before write", 1'b1, c_read[wr_count]);
                end
                for (int l = 0; l < `PWO_LANES; l++) begin
                    check_coeff("lane result", exp_lane[wr_count][l],
                                c_wr_data_o[l*`PWO_REG_W +: `PWO_COEFF_W]);
                    check_flag("pad bit", 1'b0, c_wr_data_o[l*`PWO_REG_W + `PWO_COEFF_W]);
                end
                wr_count++;
            end
            if (done_o) done_cnt++;
            if (rd_count == `PWO_WORDS || zeroize_i) issuing = 1'b0;
            if (enable_i && !busy_o) begin
                rd_count = 0;
                wr_count = 0;
                done_cnt = 0;
                issuing  = 1'b1;
                for (int w = 0; w < `PWO_WORDS; w++) c_read[w] = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // ========================================
    // Test sequence
    // ========================================

    task automatic load_tests();
        tests[0] = '{"mul",               PWO_MUL, 1'b0, 1'b0, 1'b0, 15'h0000, 15'h0100, 15'h0200};
        tests[1] = '{"mul_acc",           PWO_MUL, 1'b1, 1'b0, 1'b0, 15'h0400, 15'h0500, 15'h0600};
        tests[2] = '{"add",               PWO_ADD, 1'b1, 1'b0, 1'b0, 15'h1000, 15'h2000, 15'h3000};
        tests[3] = '{"sub",               PWO_SUB, 1'b0, 1'b0, 1'b0, 15'h1100, 15'h2100, 15'h3100};
        tests[4] = '{"mul_stall",         PWO_MUL, 1'b0, 1'b1, 1'b0, 15'h4000, 15'h4100, 15'h4200};
        tests[5] = '{"zeroize",           PWO_MUL, 1'b0, 1'b0, 1'b1, 15'h5000, 15'h5100, 15'h5200};
        tests[6] = '{"mul_after_zeroize", PWO_MUL, 1'b1, 1'b1, 1'b0, 15'h6000, 15'h6100, 15'h6200};
    endtask

    task automatic fill_operands();
        coeff_t    a;
        coeff_t    b;
        coeff_t    c;
        mem_word_t wa;
        mem_word_t wb;
        mem_word_t wc;
        for (int w = 0; w < `PWO_WORDS; w++) begin
            wa = '0;
            wb = '0;
            wc = '0;
            for (int l = 0; l < `PWO_LANES; l++) begin
                next_coeff(a);
                next_coeff(b);
                next_coeff(c);
                wa[l*`PWO_REG_W +: `PWO_COEFF_W] = a;
                wb[l*`PWO_REG_W +: `PWO_COEFF_W] = b;
                wc[l*`PWO_REG_W +: `PWO_COEFF_W] = c;
                exp_lane[w][l] = model_coeff(cur.mode, cur.acc, a, b, c);
            end
            mem_a[cur.base_a + mem_addr_t'(w)] = wa;
            mem_b[cur.base_b + mem_addr_t'(w)] = wb;
            mem_c[cur.base_c + mem_addr_t'(w)] = wc;
        end
    endtask

    task automatic check_idle(input string when);
        check_flag({"busy_o ", when}, 1'b0, busy_o);
        check_flag({"done_o ", when}, 1'b0, done_o);
        check_flag({"read enable ", when}, 1'b0, a_rd_en_o | b_rd_en_o | c_rd_en_o);
        check_flag({"c_wr_en_o ", when}, 1'b0, c_wr_en_o);
    endtask

    // Gate closed on about one cycle in four
    task automatic drive_sampler();
        logic [31:0] r;
        if (cur.stall) begin
            rand_bits(2, r);
            sampler_valid_i = |r[1:0];
        end else begin
            sampler_valid_i = 1'b1;
        end
    endtask

    task automatic run_test(input int t);
        int   n;
        logic seen;
        cur = tests[t];
        fill_operands();
        @(negedge clk);
        check_idle("before start");
        mode_i          = cur.mode;
        accumulate_i    = cur.acc;
        base_a_i        = cur.base_a;
        base_b_i        = cur.base_b;
        base_c_i        = cur.base_c;
        sampler_valid_i = 1'b1;
        enable_i        = 1'b1;
        @(negedge clk);
        enable_i = 1'b0;
        check_flag("busy_o after start", 1'b1, busy_o);
        drive_sampler();
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            n++;
            if (done_o) begin
                seen = 1'b1;
            end else if (cur.zero && n == 30) begin
                zeroize_i = 1'b1;
                @(negedge clk);
                zeroize_i = 1'b0;
                check_idle("after zeroize");
                repeat (10) begin
                    @(negedge clk);
                    check_idle("after zeroize");
                end
                check_flag("no done after zeroize", 1'b0, done_cnt != 0);
                seen = 1'b1;
            end else begin
                drive_sampler();
            end
        end
        sampler_valid_i = 1'b1;
        if (!cur.zero) begin
            check_flag("busy_o low with done_o", 1'b0, busy_o);
            check_flag("all 64 reads issued", 1'b1, rd_count == `PWO_WORDS);
            check_flag("all 64 words written", 1'b1, wr_count == `PWO_WORDS);
            @(negedge clk);
            check_flag("done_o one cycle", 1'b0, done_o);
            check_flag("single done pulse", 1'b1, done_cnt == 1);
        end
    endtask

    initial begin
        lfsr            = 32'hb1bb808b;
        reset_n         = 1'b0;
        zeroize_i       = 1'b0;
        enable_i        = 1'b0;
        accumulate_i    = 1'b0;
        sampler_valid_i = 1'b0;
        mode_i          = PWO_MUL;
        base_a_i        = '0;
        base_b_i        = '0;
        base_c_i        = '0;
        load_tests();
        cur = tests[0];
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        check_idle("after reset");
        for (int t = 0; t < NUM_TESTS; t++) run_test(t);
        $display("** PASS **");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
verilog/pwo_pkg.sv
verilog/pwo_issue_if.sv
verilog/pwo_lane.sv
verilog/pwo_ctrl.sv
verilog/pwo_datapath.sv
verilog/pwo_top.sv
tb/pwo_tb.sv

// File: Makefile
TOOL       := verilator
TOP        := pwo_tb
FILELIST   := list.f
VFLAGS     := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation status alone is not trusted, the log decides
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '$(PASS_TEXT)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
